// ==== fft_axi_pkg.sv ====
package fft_axi_pkg;

    // --------------------
    // Bus and sample widths
    // --------------------

    // One complex sample fills exactly one bus word
    localparam int DATA_WIDTH   = 32;
    localparam int SAMPLE_WIDTH = 16;

    // Byte offset bits below the word index
    localparam int ADDR_LSB = 2;

    // Word index after the byte offset is dropped
    typedef logic [4:0] word_idx_t;

    // --------------------
    // Register map
    // --------------------

    // Result k lives at REG_RESULT_BASE + k
    typedef enum word_idx_t {
        REG_CTRL        = 5'd0,
        REG_STATUS      = 5'd1,
        REG_RESULT_BASE = 5'd2
    } reg_idx_e;

    // Control and status bit positions
    localparam int CTRL_START_BIT  = 0;
    localparam int CTRL_CLEAR_BIT  = 1;
    localparam int STATUS_DONE_BIT = 0;

    // Write channel FSM
    typedef enum logic {
        WR_IDLE,
        WR_RESP
    } wr_state_e;

    // Register write request from the bus side
    typedef struct packed {
        logic                  en;
        word_idx_t             idx;
        logic [DATA_WIDTH-1:0] data;
    } reg_wr_t;

    // Result sample, real part in the upper half of the word
    typedef struct packed {
        logic [SAMPLE_WIDTH-1:0] re;
        logic [SAMPLE_WIDTH-1:0] im;
    } fft_sample_t;

endpackage

// ==== axi_lite_slave.sv ====
`timescale 1ns/1ps

module axi_lite_slave #(
    parameter int ADDR_WIDTH = 7
) (
    input  logic                               S_AXI_ACLK,
    input  logic                               S_AXI_ARESETN,
    // Write address and data
    input  logic [ADDR_WIDTH-1:0]              S_AXI_AWADDR,
    input  logic                               S_AXI_AWVALID,
    output logic                               S_AXI_AWREADY,
    input  logic [fft_axi_pkg::DATA_WIDTH-1:0] S_AXI_WDATA,
    input  logic                               S_AXI_WVALID,
    output logic                               S_AXI_WREADY,
    // Write response
    output logic [1:0]                         S_AXI_BRESP,
    output logic                               S_AXI_BVALID,
    input  logic                               S_AXI_BREADY,
    // Read address and data
    input  logic [ADDR_WIDTH-1:0]              S_AXI_ARADDR,
    input  logic                               S_AXI_ARVALID,
    output logic                               S_AXI_ARREADY,
    output logic [fft_axi_pkg::DATA_WIDTH-1:0] S_AXI_RDATA,
    output logic [1:0]                         S_AXI_RRESP,
    output logic                               S_AXI_RVALID,
    input  logic                               S_AXI_RREADY,
    // Register map side
    input  logic [fft_axi_pkg::DATA_WIDTH-1:0] rd_data,
    output fft_axi_pkg::reg_wr_t               reg_wr,
    output fft_axi_pkg::word_idx_t             rd_idx
);
    import fft_axi_pkg::*;

    localparam int         IDX_BITS  = $bits(word_idx_t);
    localparam logic [1:0] RESP_OKAY = 2'b00;

    // --------------------
    // Write channel
    // --------------------

    wr_state_e             wr_state;
    logic                  axi_awready;
    logic                  wr_accept;
    word_idx_t             aw_idx;
    logic [DATA_WIDTH-1:0] w_data;

    // Both valids in idle, and no ready pulse already in flight
    assign wr_accept = (wr_state == WR_IDLE) && !axi_awready
                       && S_AXI_AWVALID && S_AXI_WVALID;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            wr_state    <= WR_IDLE;
            axi_awready <= 1'b0;
        end
        else
        begin
            // Single cycle ready pulse for address and data together
            axi_awready <= wr_accept;
            case (wr_state)
                WR_IDLE:
                begin
                    // Register is written this cycle, response follows
                    if (axi_awready)
                    begin
                        wr_state <= WR_RESP;
                    end
                end
                WR_RESP:
                begin
                    if (S_AXI_BREADY)
                    begin
                        wr_state <= WR_IDLE;
                    end
                end
                default:
                begin
                    wr_state <= WR_IDLE;
                end
            endcase
        end
    end

    // Address and data captured as the handshake is granted
    always_ff @(posedge S_AXI_ACLK)
    begin
        if (wr_accept)
        begin
            aw_idx <= S_AXI_AWADDR[ADDR_LSB +: IDX_BITS];
            w_data <= S_AXI_WDATA;
        end
    end

    // Request is live only during the ready cycle
    assign reg_wr = '{en: axi_awready, idx: aw_idx, data: w_data};

    assign S_AXI_AWREADY = axi_awready;
    assign S_AXI_WREADY  = axi_awready;
    assign S_AXI_BVALID  = (wr_state == WR_RESP);
    assign S_AXI_BRESP   = RESP_OKAY;

    // --------------------
    // Read channel
    // --------------------

    logic                  axi_arready;
    logic                  axi_rvalid;
    logic                  rd_accept;
    word_idx_t             ar_idx;
    logic [DATA_WIDTH-1:0] axi_rdata;

    // One read at a time, held off while data waits for RREADY
    assign rd_accept = !axi_arready && !axi_rvalid && S_AXI_ARVALID;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            axi_arready <= 1'b0;
            axi_rvalid  <= 1'b0;
        end
        else
        begin
            axi_arready <= rd_accept;
            if (axi_arready)
            begin
                axi_rvalid <= 1'b1;
            end
            else if (axi_rvalid && S_AXI_RREADY)
            begin
                axi_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (rd_accept)
        begin
            ar_idx <= S_AXI_ARADDR[ADDR_LSB +: IDX_BITS];
        end
        // Register map answers combinationally from the latched index
        if (axi_arready)
        begin
            axi_rdata <= rd_data;
        end
    end

    assign rd_idx        = ar_idx;
    assign S_AXI_ARREADY = axi_arready;
    assign S_AXI_RVALID  = axi_rvalid;
    assign S_AXI_RDATA   = axi_rdata;
    assign S_AXI_RRESP   = RESP_OKAY;

    // --------------------
    // Protocol checks
    // --------------------

    // Response is held until the master takes it
    a_bvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_BVALID && !S_AXI_BREADY |=> S_AXI_BVALID);

    // Read data stays valid and unchanged until accepted
    a_rvalid_hold: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        S_AXI_RVALID && !S_AXI_RREADY |=> S_AXI_RVALID && $stable(S_AXI_RDATA));

endmodule

// ==== fft_reg_map.sv ====
`timescale 1ns/1ps

module fft_reg_map #(
    parameter  int N_RESULTS = 16,
    localparam int IDX_W     = $clog2(N_RESULTS)
) (
    input  logic                               S_AXI_ACLK,
    input  logic                               S_AXI_ARESETN,
    // Bus side
    input  fft_axi_pkg::reg_wr_t               reg_wr,
    input  fft_axi_pkg::word_idx_t             rd_idx,
    output logic [fft_axi_pkg::DATA_WIDTH-1:0] rd_data,
    // Capture bank side
    input  logic                               done_pulse,
    input  fft_axi_pkg::fft_sample_t           slot_data,
    output logic [IDX_W-1:0]                   slot_idx,
    output logic                               capture_clear,
    // Core controls
    output logic                               fft_start,
    output logic                               fft_clear
);
    import fft_axi_pkg::*;

    logic [DATA_WIDTH-1:0] ctrl_q;
    logic                  done_q;
    logic                  wr_ctrl;
    logic                  wr_status;
    logic                  in_results;
    word_idx_t             slot_off;

    // --------------------
    // Write decode
    // --------------------

    always_comb
    begin
        wr_ctrl   = 1'b0;
        wr_status = 1'b0;
        case (reg_wr.idx)
            REG_CTRL:   wr_ctrl   = reg_wr.en;
            REG_STATUS: wr_status = reg_wr.en;
            // Result words are read-only, write is dropped
            default:    ;
        endcase
    end

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            ctrl_q <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            if (wr_ctrl)
            begin
                ctrl_q <= reg_wr.data;
            end
            // Software write to status beats a done pulse in the same cycle
            if (wr_status)
            begin
                done_q <= reg_wr.data[STATUS_DONE_BIT];
            end
            else if (done_pulse)
            begin
                done_q <= 1'b1;
            end
        end
    end

    // Control bits go straight out as levels
    assign fft_start     = ctrl_q[CTRL_START_BIT];
    assign fft_clear     = ctrl_q[CTRL_CLEAR_BIT];
    assign capture_clear = ctrl_q[CTRL_CLEAR_BIT];

    // --------------------
    // Read multiplexer
    // --------------------

    // Slot number relative to the first result word
    assign slot_off   = rd_idx - word_idx_t'(REG_RESULT_BASE);
    assign slot_idx   = slot_off[IDX_W-1:0];
    assign in_results = int'(rd_idx) < int'(REG_RESULT_BASE) + N_RESULTS;

    always_comb
    begin
        rd_data = '0;
        case (rd_idx)
            REG_CTRL:   rd_data = ctrl_q;
            REG_STATUS: rd_data[STATUS_DONE_BIT] = done_q;
            default:
            begin
                // Anything past the last result reads as zero
                if (in_results)
                begin
                    rd_data = slot_data;
                end
            end
        endcase
    end

endmodule

// ==== fft_result_capture.sv ====
`timescale 1ns/1ps

module fft_result_capture #(
    parameter  int N_RESULTS = 16,
    localparam int IDX_W     = $clog2(N_RESULTS)
) (
    input  logic                     S_AXI_ACLK,
    input  logic                     S_AXI_ARESETN,
    // Core result stream
    input  logic                     result_valid,
    input  fft_axi_pkg::fft_sample_t result,
    // Register map side
    input  logic                     capture_clear,
    input  logic [IDX_W-1:0]         slot_idx,
    output fft_axi_pkg::fft_sample_t slot_data,
    output logic                     done_pulse
);
    import fft_axi_pkg::*;

    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(N_RESULTS - 1);

    fft_sample_t      bank [N_RESULTS];
    logic [IDX_W-1:0] idx_q;
    logic             store;

    // Samples are dropped while clear is held
    assign store = result_valid && !capture_clear;

    always_ff @(posedge S_AXI_ACLK)
    begin
        if (!S_AXI_ARESETN)
        begin
            idx_q      <= '0;
            done_pulse <= 1'b0;
            for (int i = 0; i < N_RESULTS; i++)
            begin
                bank[i] <= '0;
            end
        end
        else
        begin
            // Done follows the edge that stores the last slot
            done_pulse <= store && (idx_q == LAST_IDX);
            if (capture_clear)
            begin
                idx_q <= '0;
            end
            else if (store)
            begin
                bank[idx_q] <= result;
                idx_q       <= (idx_q == LAST_IDX) ? '0 : idx_q + 1'b1;
            end
        end
    end

    // Read port for the register map
    assign slot_data = bank[slot_idx];

    // Index wraps before running off the bank
    a_idx_range: assert property (@(posedge S_AXI_ACLK) disable iff (!S_AXI_ARESETN)
        int'(idx_q) < N_RESULTS);

endmodule

// ==== fft_axi_top.sv ====
`timescale 1ns/1ps

module fft_axi_top #(
    parameter int ADDR_WIDTH = 7,
    parameter int N_RESULTS  = 16
) (
    input  logic                               S_AXI_ACLK,
    input  logic                               S_AXI_ARESETN,
    input  logic [ADDR_WIDTH-1:0]              S_AXI_AWADDR,
    input  logic                               S_AXI_AWVALID,
    output logic                               S_AXI_AWREADY,
    input  logic [fft_axi_pkg::DATA_WIDTH-1:0] S_AXI_WDATA,
    input  logic                               S_AXI_WVALID,
    output logic                               S_AXI_WREADY,
    output logic [1:0]                         S_AXI_BRESP,
    output logic                               S_AXI_BVALID,
    input  logic                               S_AXI_BREADY,
    input  logic [ADDR_WIDTH-1:0]              S_AXI_ARADDR,
    input  logic                               S_AXI_ARVALID,
    output logic                               S_AXI_ARREADY,
    output logic [fft_axi_pkg::DATA_WIDTH-1:0] S_AXI_RDATA,
    output logic [1:0]                         S_AXI_RRESP,
    output logic                               S_AXI_RVALID,
    input  logic                               S_AXI_RREADY,
    // FFT core side
    output logic                               fft_start,
    output logic                               fft_clear,
    input  logic                               result_valid,
    input  fft_axi_pkg::fft_sample_t           result
);
    import fft_axi_pkg::*;

    localparam int IDX_W = $clog2(N_RESULTS);

    // Bus to register map
    reg_wr_t               reg_wr;
    word_idx_t             rd_idx;
    logic [DATA_WIDTH-1:0] rd_data;

    // Register map to capture bank
    logic [IDX_W-1:0]      slot_idx;
    fft_sample_t           slot_data;
    logic                  done_pulse;
    logic                  capture_clear;

    axi_lite_slave #(
        .ADDR_WIDTH(ADDR_WIDTH)
    ) u_slave (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .S_AXI_AWADDR (S_AXI_AWADDR),
        .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA  (S_AXI_WDATA),
        .S_AXI_WVALID (S_AXI_WVALID),
        .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BRESP  (S_AXI_BRESP),
        .S_AXI_BVALID (S_AXI_BVALID),
        .S_AXI_BREADY (S_AXI_BREADY),
        .S_AXI_ARADDR (S_AXI_ARADDR),
        .S_AXI_ARVALID(S_AXI_ARVALID),
        .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RDATA  (S_AXI_RDATA),
        .S_AXI_RRESP  (S_AXI_RRESP),
        .S_AXI_RVALID (S_AXI_RVALID),
        .S_AXI_RREADY (S_AXI_RREADY),
        .rd_data      (rd_data),
        .reg_wr       (reg_wr),
        .rd_idx       (rd_idx)
    );

    fft_reg_map #(
        .N_RESULTS(N_RESULTS)
    ) u_reg_map (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .reg_wr       (reg_wr),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data),
        .done_pulse   (done_pulse),
        .slot_data    (slot_data),
        .slot_idx     (slot_idx),
        .capture_clear(capture_clear),
        .fft_start    (fft_start),
        .fft_clear    (fft_clear)
    );

    fft_result_capture #(
        .N_RESULTS(N_RESULTS)
    ) u_capture (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .result_valid (result_valid),
        .result       (result),
        .capture_clear(capture_clear),
        .slot_idx     (slot_idx),
        .slot_data    (slot_data),
        .done_pulse   (done_pulse)
    );

endmodule

// ==== tb_fft_axi_top.sv ====
`timescale 1ns/1ps

module tb_fft_axi_top;
    import fft_axi_pkg::*;

    localparam int ADDR_WIDTH    = 7;
    localparam int N_RESULTS     = 16;
    // Longest wait allowed for any one handshake
    localparam int HS_LIMIT      = 32;
    // Watchdog budget per operation in the data file
    localparam int CYCLES_PER_OP = 40;

    logic                  S_AXI_ACLK = 1'b0;
    logic                  S_AXI_ARESETN;
    logic [ADDR_WIDTH-1:0] S_AXI_AWADDR;
    logic                  S_AXI_AWVALID;
    logic                  S_AXI_AWREADY;
    logic [DATA_WIDTH-1:0] S_AXI_WDATA;
    logic                  S_AXI_WVALID;
    logic                  S_AXI_WREADY;
    logic [1:0]            S_AXI_BRESP;
    logic                  S_AXI_BVALID;
    logic                  S_AXI_BREADY;
    logic [ADDR_WIDTH-1:0] S_AXI_ARADDR;
    logic                  S_AXI_ARVALID;
    logic                  S_AXI_ARREADY;
    logic [DATA_WIDTH-1:0] S_AXI_RDATA;
    logic [1:0]            S_AXI_RRESP;
    logic                  S_AXI_RVALID;
    logic                  S_AXI_RREADY;
    logic                  fft_start;
    logic                  fft_clear;
    logic                  result_valid;
    fft_sample_t           result;

    // Operations loaded from the data file
    byte         op_q[$];
    logic [31:0] arg_a_q[$];
    logic [31:0] arg_b_q[$];
    bit          ops_loaded = 1'b0;

    int n_checks = 0;
    int n_errors = 0;

    // 10 ns clock
    always #5 S_AXI_ACLK = ~S_AXI_ACLK;

    fft_axi_top #(
        .ADDR_WIDTH(ADDR_WIDTH),
        .N_RESULTS (N_RESULTS)
    ) dut (
        .S_AXI_ACLK   (S_AXI_ACLK),
        .S_AXI_ARESETN(S_AXI_ARESETN),
        .S_AXI_AWADDR (S_AXI_AWADDR),
        .S_AXI_AWVALID(S_AXI_AWVALID),
        .S_AXI_AWREADY(S_AXI_AWREADY),
        .S_AXI_WDATA  (S_AXI_WDATA),
        .S_AXI_WVALID (S_AXI_WVALID),
        .S_AXI_WREADY (S_AXI_WREADY),
        .S_AXI_BRESP  (S_AXI_BRESP),
        .S_AXI_BVALID (S_AXI_BVALID),
        .S_AXI_BREADY (S_AXI_BREADY),
        .S_AXI_ARADDR (S_AXI_ARADDR),
        .S_AXI_ARVALID(S_AXI_ARVALID),
        .S_AXI_ARREADY(S_AXI_ARREADY),
        .S_AXI_RDATA  (S_AXI_RDATA),
        .S_AXI_RRESP  (S_AXI_RRESP),
        .S_AXI_RVALID (S_AXI_RVALID),
        .S_AXI_RREADY (S_AXI_RREADY),
        .fft_start    (fft_start),
        .fft_clear    (fft_clear),
        .result_valid (result_valid),
        .result       (result)
    );

    // --------------------
    // Helpers
    // --------------------

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        n_checks++;
        if (actual !== expected)
        begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, actual, expected);
            n_errors++;
        end
    endtask

    // Reads one operation per line and skips lines starting with #
    task automatic load_ops(output bit ok);
        int          fd;
        int          n;
        string       line;
        logic [31:0] a;
        logic [31:0] b;
        ok = 1'b0;
        fd = $fopen("fft_axi_input.txt", "r");
        if (fd != 0)
        begin
            ok = 1'b1;
            while (!$feof(fd))
            begin
                line = "";
                n = $fgets(line, fd);
                if (n > 0 && line.len() > 2 && line.getc(0) != "#")
                begin
                    n = $sscanf(line.substr(2, line.len() - 1), "%h %h", a, b);
                    if (n != 2)
                    begin
                        $display("Malformed line in stimulus file: %s", line);
                        n_errors++;
                    end
                    else
                    begin
                        op_q.push_back(line.getc(0));
                        arg_a_q.push_back(a);
                        arg_b_q.push_back(b);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Address and data together, then the response after a random delay
    task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
        int cycles;
        int delay;
        delay = int'($urandom % 4);
        @(posedge S_AXI_ACLK);
        S_AXI_AWADDR  <= addr[ADDR_WIDTH-1:0];
        S_AXI_AWVALID <= 1'b1;
        S_AXI_WDATA   <= data;
        S_AXI_WVALID  <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge S_AXI_ACLK);
            cycles++;
        end
        while (!(S_AXI_AWREADY && S_AXI_WREADY) && cycles < HS_LIMIT);
        if (!(S_AXI_AWREADY && S_AXI_WREADY))
        begin
            $display("Timeout: write to 0x%02h was never accepted", addr[7:0]);
            n_errors++;
        end
        // Handshake completes on this edge
        @(posedge S_AXI_ACLK);
        S_AXI_AWVALID <= 1'b0;
        S_AXI_WVALID  <= 1'b0;
        repeat (delay) @(posedge S_AXI_ACLK);
        S_AXI_BREADY <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge S_AXI_ACLK);
            cycles++;
        end
        while (!S_AXI_BVALID && cycles < HS_LIMIT);
        if (!S_AXI_BVALID)
        begin
            $display("Timeout: no write response for address 0x%02h", addr[7:0]);
            n_errors++;
        end
        else
        begin
            check_value("S_AXI_BRESP", 32'(S_AXI_BRESP), 32'h0);
            // Ready pulses last a single cycle
            check_value("S_AXI_AWREADY", 32'(S_AXI_AWREADY), 32'h0);
            check_value("S_AXI_WREADY", 32'(S_AXI_WREADY), 32'h0);
        end
        @(posedge S_AXI_ACLK);
        S_AXI_BREADY <= 1'b0;
    endtask

    task automatic read_word(input logic [31:0] addr, input logic [31:0] expected);
        int cycles;
        int delay;
        delay = int'($urandom % 4);
        @(posedge S_AXI_ACLK);
        S_AXI_ARADDR  <= addr[ADDR_WIDTH-1:0];
        S_AXI_ARVALID <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge S_AXI_ACLK);
            cycles++;
        end
        while (!S_AXI_ARREADY && cycles < HS_LIMIT);
        if (!S_AXI_ARREADY)
        begin
            $display("Timeout: read of 0x%02h was never accepted", addr[7:0]);
            n_errors++;
        end
        @(posedge S_AXI_ACLK);
        S_AXI_ARVALID <= 1'b0;
        repeat (delay) @(posedge S_AXI_ACLK);
        S_AXI_RREADY <= 1'b1;
        cycles = 0;
        do
        begin
            @(negedge S_AXI_ACLK);
            cycles++;
        end
        while (!S_AXI_RVALID && cycles < HS_LIMIT);
        if (!S_AXI_RVALID)
        begin
            $display("Timeout: no read data for address 0x%02h", addr[7:0]);
            n_errors++;
        end
        else
        begin
            check_value($sformatf("S_AXI_RDATA at 0x%02h", addr[7:0]), S_AXI_RDATA, expected);
            check_value("S_AXI_RRESP", 32'(S_AXI_RRESP), 32'h0);
            check_value("S_AXI_ARREADY", 32'(S_AXI_ARREADY), 32'h0);
        end
        @(posedge S_AXI_ACLK);
        S_AXI_RREADY <= 1'b0;
    endtask

    // Single cycle strobe followed by one idle cycle as the gap
    task automatic present_sample(input logic [15:0] re_val, input logic [15:0] im_val);
        @(posedge S_AXI_ACLK);
        result_valid <= 1'b1;
        result       <= '{re: re_val, im: im_val};
        @(posedge S_AXI_ACLK);
        result_valid <= 1'b0;
    endtask

    task automatic check_levels(input logic start_exp, input logic clear_exp);
        @(negedge S_AXI_ACLK);
        check_value("fft_start", 32'(fft_start), 32'(start_exp));
        check_value("fft_clear", 32'(fft_clear), 32'(clear_exp));
    endtask

    // --------------------
    // Main sequence
    // --------------------

    initial
    begin
        bit file_ok;
        void'($urandom(32'hb8bf));
        S_AXI_ARESETN = 1'b0;
        S_AXI_AWADDR  = '0;
        S_AXI_AWVALID = 1'b0;
        S_AXI_WDATA   = '0;
        S_AXI_WVALID  = 1'b0;
        S_AXI_BREADY  = 1'b0;
        S_AXI_ARADDR  = '0;
        S_AXI_ARVALID = 1'b0;
        S_AXI_RREADY  = 1'b0;
        result_valid  = 1'b0;
        result        = '0;
        load_ops(file_ok);
        if (!file_ok)
        begin
            $display("Could not open stimulus file fft_axi_input.txt");
            n_errors++;
        end
        else
        begin
            ops_loaded = 1'b1;
            repeat (8) @(posedge S_AXI_ACLK);
            S_AXI_ARESETN <= 1'b1;
            for (int i = 0; i < op_q.size(); i++)
            begin
                case (op_q[i])
                    "W": write_word(arg_a_q[i], arg_b_q[i]);
                    "R": read_word(arg_a_q[i], arg_b_q[i]);
                    "S": present_sample(arg_a_q[i][15:0], arg_b_q[i][15:0]);
                    "L": check_levels(arg_a_q[i][0], arg_b_q[i][0]);
                    default:
                    begin
                        $display("Unknown operation '%c' in stimulus file", op_q[i]);
                        n_errors++;
                    end
                endcase
            end
        end
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0)
        begin
            $display("All tests passed!");
        end
        else
        begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog sized from the number of operations
    initial
    begin
        wait (ops_loaded);
        repeat ((op_q.size() + 8) * CYCLES_PER_OP) @(posedge S_AXI_ACLK);
        $display("Watchdog expired, the run took too long and was stopped");
        $display("Checks run: %0d, errors: %0d", n_checks, n_errors);
        $display("Test failures found");
        $finish;
    end

endmodule

// ==== fft_axi_input.txt ====
# op a b, all hex: W addr data | R addr expected | S re im | L start clear
# Byte addresses, word k sits at 4*k, results start at 0x08
# After reset everything reads zero
L 0 0
R 00 00000000
R 04 00000000
R 08 00000000
R 0c 00000000
R 10 00000000
R 14 00000000
R 18 00000000
R 1c 00000000
R 20 00000000
R 24 00000000
R 28 00000000
R 2c 00000000
R 30 00000000
R 34 00000000
R 38 00000000
R 3c 00000000
R 40 00000000
R 44 00000000
# Start and clear levels follow the control word
W 00 5a5a0003
L 1 1
R 00 5a5a0003
W 00 00000000
L 0 0
R 00 00000000
# Sixteen samples, done only after the last one
S a000 500c
S a101 511c
S a202 522c
S a303 533c
S a404 544c
S a505 555c
S a606 566c
S a707 577c
S a808 588c
S a909 599c
S aa0a 5aac
S ab0b 5bbc
S ac0c 5ccc
S ad0d 5ddc
S ae0e 5eec
R 04 00000000
S af0f 5ffc
R 04 00000001
R 08 a000500c
R 0c a101511c
R 10 a202522c
R 14 a303533c
R 18 a404544c
R 1c a505555c
R 20 a606566c
R 24 a707577c
R 28 a808588c
R 2c a909599c
R 30 aa0a5aac
R 34 ab0b5bbc
R 38 ac0c5ccc
R 3c ad0d5ddc
R 40 ae0e5eec
R 44 af0f5ffc
# Done cleared by software, result words are read-only
W 04 00000000
R 04 00000000
W 08 deadbeef
W 44 0badf00d
R 08 a000500c
R 44 af0f5ffc
# Two samples move the index, clear rewinds it and drops samples
S 7777 8888
S 6666 9999
R 08 77778888
W 00 00000002
L 0 1
S 1111 2222
S 1111 2222
S 1111 2222
S 1111 2222
S 1111 2222
W 00 00000000
L 0 0
S 1234 5678
S 9abc def0
S 0f1e 2d3c
R 08 12345678
R 0c 9abcdef0
R 10 0f1e2d3c
R 14 a303533c
R 18 a404544c
R 1c a505555c
R 20 a606566c
R 24 a707577c
R 28 a808588c
R 2c a909599c
R 30 aa0a5aac
R 34 ab0b5bbc
R 38 ac0c5ccc
R 3c ad0d5ddc
R 40 ae0e5eec
R 44 af0f5ffc
R 04 00000000
# Unmapped words read zero, a write there changes nothing
W 48 ffffffff
R 48 00000000
R 60 00000000
R 7c 00000000
R 00 00000000

// ==== Makefile ====
VERILATOR  := verilator
TOP        := tb_fft_axi_top
FILELIST   := fft_axi_top.f
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert
PASS_MSG   := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

# Pass only if the simulation output holds the pass message
sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// ==== fft_axi_top.f ====
fft_axi_pkg.sv
axi_lite_slave.sv
fft_reg_map.sv
fft_result_capture.sv
fft_axi_top.sv
tb_fft_axi_top.sv
